// File: Bender.yml
package:
  name: pipelineCore

sources:
  - files:
      - verilog/coreDefs.sv
      - verilog/hostPort.sv
      - verilog/fetchStage.sv
      - verilog/registerFile.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/pipelineCore.sv
  - target: test
    files:
      - bench/pipelineCore_assertions.sv
      - bench/pipelineCoreTb.sv

// File: bench/pipelineCoreTb.sv
`timescale 1ns/1ps

module pipelineCoreTb
	import coreDefs::*;
();

	localparam int ImemAddrWidth = 8;
	// Program sizes, eop included
	localparam int RandOps       = 16;
	localparam int ChainLen      = 24;
	localparam int Prog1Len      = 15 * 2 + 8 + RandOps + 1;
	localparam int Prog2Len      = ChainLen + 1;
	localparam int Prog3Len      = 16;
	localparam int TotalInstr    = Prog1Len + Prog2Len + Prog3Len;
	localparam int TimeoutCycles = 200 * TotalInstr + 2000;

	logic                     clk;
	logic                     rstN;
	logic                     hostReq;
	hostCmdT                  hostCmd;
	logic [ImemAddrWidth-1:0] hostAddr;
	dataT                     hostWdata;
	logic                     hostAck;
	dataT                     hostRdata;

	// Reference register state and current program
	dataT model [32];
	dataT prog [$];
	int   checkCount = 0;
	int   errorCount = 0;

	pipelineCore #(
		.ImemAddrWidth (ImemAddrWidth)
	) dut_i (
		.clk       (clk),
		.rstN      (rstN),
		.hostReq   (hostReq),
		.hostCmd   (hostCmd),
		.hostAddr  (hostAddr),
		.hostWdata (hostWdata),
		.hostAck   (hostAck),
		.hostRdata (hostRdata)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////
	function automatic dataT encR(regAddrT rd, regAddrT rs, regAddrT rt,
		logic [4:0] shamt, logic [5:0] fn);
		return {OpRType, rs, rt, rd, shamt, fn};
	endfunction

	function automatic dataT encI(logic [5:0] op, regAddrT rt, regAddrT rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [5:0] randomFunct();
		case ($urandom_range(7))
			0: return FnAdd;
			1: return FnSub;
			2: return FnAnd;
			3: return FnOr;
			4: return FnXor;
			5: return FnSlt;
			6: return FnSll;
			default: return FnSrl;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic void modelStep(dataT instr);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  shamt;
		logic [15:0] imm;
		regAddrT     dst;
		dataT        a;
		dataT        b;
		dataT        res;
		logic        wr;
		op    = instr[31:26];
		fn    = instr[5:0];
		shamt = instr[10:6];
		imm   = instr[15:0];
		a     = model[instr[25:21]];
		b     = model[instr[20:16]];
		dst   = instr[20:16];
		res   = '0;
		wr    = 1'b1;
		case (op)
			OpRType: begin
				dst = instr[15:11];
				case (fn)
					FnAdd: res = a + b;
					FnSub: res = a - b;
					FnAnd: res = a & b;
					FnOr:  res = a | b;
					FnXor: res = a ^ b;
					FnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FnSll: res = b << shamt;
					FnSrl: res = b >> shamt;
					default: wr = 1'b0;
				endcase
			end
			// Sign-extended add, zero-extended logic ops
			OpAddi: res = a + {{16{imm[15]}}, imm};
			OpAndi: res = a & {16'h0000, imm};
			OpOri:  res = a | {16'h0000, imm};
			OpLui:  res = {imm, 16'h0000};
			default: wr = 1'b0;
		endcase
		// R0 stays zero
		if (wr && dst != '0) begin
			model[dst] = res;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////////////////////////
	task automatic hostTransfer(input hostCmdT cmd, input logic [ImemAddrWidth-1:0] addr,
		input dataT wdata, output dataT rdata);
		@(posedge clk);
		hostCmd   <= cmd;
		hostAddr  <= addr;
		hostWdata <= wdata;
		hostReq   <= 1'b1;
		// Ack phase
		do @(posedge clk); while (!hostAck);
		rdata = hostRdata;
		hostReq <= 1'b0;
		// Wait for ack to drop
		do @(posedge clk); while (hostAck);
	endtask

	task automatic checkRegs();
		dataT got;
		for (int r = 0; r < 32; r++) begin
			hostTransfer(CmdRead, ImemAddrWidth'(r), '0, got);
			checkCount++;
			assert (got === model[r]) else begin
				errorCount++;
				$display("Error: time %0t, hostRdata (r%0d): expected %08h, actual %08h",
					$time, r, model[r], got);
			end
		end
	endtask

	// Load, run, then step the model up to eop
	task automatic runProgram();
		dataT unused;
		for (int i = 0; i < prog.size(); i++) begin
			hostTransfer(CmdLoad, ImemAddrWidth'(i), prog[i], unused);
		end
		hostTransfer(CmdRun, '0, '0, unused);
		for (int i = 0; i < prog.size(); i++) begin
			modelStep(prog[i]);
			if (prog[i][31:26] == OpEop) begin
				break;
			end
		end
		checkRegs();
	endtask

	////////////////////////////////////////////////////////////
	// Programs
	////////////////////////////////////////////////////////////
	// Random fill, then independent R-type into r24..r31
	task automatic buildRandomProgram();
		prog.delete();
		for (int r = 1; r < 16; r++) begin
			prog.push_back(encI(OpLui, regAddrT'(r), '0, 16'($urandom())));
			prog.push_back(encI(OpOri, regAddrT'(r), regAddrT'(r), 16'($urandom())));
		end
		for (int r = 16; r < 24; r++) begin
			prog.push_back(encI(OpAddi, regAddrT'(r), '0, 16'($urandom())));
		end
		for (int i = 0; i < RandOps; i++) begin
			prog.push_back(encR(regAddrT'(24 + i % 8), regAddrT'(1 + $urandom_range(22)),
				regAddrT'(1 + $urandom_range(22)), 5'($urandom()), randomFunct()));
		end
		prog.push_back({OpEop, 26'h0});
	endtask

	// rs from previous instr (EX/WB path), rt from one or two back (write-through)
	task automatic buildChainProgram();
		regAddrT prev1;
		regAddrT prev2;
		regAddrT dst;
		regAddrT rt;
		prog.delete();
		prev1 = 5'd1;
		prev2 = 5'd2;
		for (int i = 0; i < ChainLen; i++) begin
			dst = regAddrT'(1 + $urandom_range(6));
			rt  = $urandom_range(1) ? prev1 : prev2;
			case ($urandom_range(5))
				0: prog.push_back(encI(OpAddi, dst, prev1, 16'($urandom())));
				1: prog.push_back(encI(OpAndi, dst, prev1, 16'($urandom())));
				2: prog.push_back(encI(OpOri, dst, prev1, 16'($urandom())));
				default: prog.push_back(encR(dst, prev1, rt, 5'($urandom()), randomFunct()));
			endcase
			prev2 = prev1;
			prev1 = dst;
		end
		prog.push_back({OpEop, 26'h0});
	endtask

	// Immediate extension, shifts, signed slt, r0 and code past eop
	task automatic buildImmediateProgram();
		prog.delete();
		prog.push_back(encI(OpAddi, 5'd1, 5'd0, 16'hfffb));
		prog.push_back(encI(OpAndi, 5'd2, 5'd1, 16'hf0f0));
		prog.push_back(encI(OpOri, 5'd3, 5'd0, 16'h8001));
		prog.push_back(encI(OpLui, 5'd4, 5'd0, 16'h8123));
		prog.push_back(encR(5'd5, 5'd0, 5'd4, 5'd4, FnSll));
		prog.push_back(encR(5'd6, 5'd0, 5'd4, 5'd8, FnSrl));
		prog.push_back(encR(5'd7, 5'd1, 5'd3, 5'd0, FnSlt));
		prog.push_back(encR(5'd8, 5'd3, 5'd1, 5'd0, FnSlt));
		prog.push_back(encR(5'd9, 5'd4, 5'd3, 5'd0, FnSlt));
		// Writes to r0, then read r0 right behind them
		prog.push_back(encI(OpAddi, 5'd0, 5'd0, 16'h0007));
		prog.push_back(encR(5'd0, 5'd1, 5'd1, 5'd0, FnAdd));
		prog.push_back(encR(5'd10, 5'd0, 5'd2, 5'd0, FnOr));
		prog.push_back({OpEop, 26'h0});
		// never issued
		prog.push_back(encI(OpAddi, 5'd11, 5'd0, 16'h0123));
		prog.push_back(encI(OpLui, 5'd12, 5'd0, 16'hdead));
		prog.push_back(encR(5'd1, 5'd2, 5'd3, 5'd0, FnAdd));
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		clk       = 1'b0;
		rstN      = 1'b0;
		hostReq   = 1'b0;
		hostCmd   = CmdLoad;
		hostAddr  = '0;
		hostWdata = '0;
		void'($urandom(6));
		for (int r = 0; r < 32; r++) begin
			model[r] = '0;
		end
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		// Registers come out of reset as zero
		checkRegs();
		buildRandomProgram();
		runProgram();
		buildChainProgram();
		runProgram();
		buildImmediateProgram();
		runProgram();
		$display("Done: %0d register checks, %0d errors, %0d assertion failures",
			checkCount, errorCount, dut_i.assertions_i.failCount);
		if (errorCount == 0 && dut_i.assertions_i.failCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog sized from the program lengths
	initial begin
		repeat (TimeoutCycles) @(posedge clk);
		$display("Timeout: run still going after %0d cycles, %0d errors so far",
			TimeoutCycles, errorCount);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: bench/pipelineCore_assertions.sv
`timescale 1ns/1ps

module pipelineCoreAssertions
	import coreDefs::*;
(
	input logic    clk,
	input logic    rstN,
	input logic    hostReq,
	input hostCmdT hostCmd,
	input logic    hostAck,
	input dataT    hostRdata,
	input logic    wbValid,
	input logic    wbEop
);

	int      failCount = 0;
	logic    reqQ;
	hostCmdT lastCmd;
	logic    eopDone;

	////////////////////////////////////////////////////////////
	// Command tracking
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqQ    <= 1'b0;
			lastCmd <= CmdLoad;
			eopDone <= 1'b0;
		end else begin
			reqQ <= hostReq;
			// New request starts a fresh transaction
			if (hostReq && !reqQ) begin
				lastCmd <= hostCmd;
				eopDone <= 1'b0;
			end else if (wbValid && wbEop) begin
				eopDone <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Handshake properties
	////////////////////////////////////////////////////////////
	// Ack rises only under a live request
	ackRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(hostAck) |-> $past(hostReq))
	else begin
		failCount++;
		$error("hostAck rose without hostReq");
	end

	// Ack drops only once req is gone
	ackFall: assert property (@(posedge clk) disable iff (!rstN)
		$fell(hostAck) |-> !$past(hostReq))
	else begin
		failCount++;
		$error("hostAck fell while hostReq was still high");
	end

	// Read data held for the whole ack phase
	rdataHold: assert property (@(posedge clk) disable iff (!rstN)
		(hostAck && $past(hostAck) && lastCmd == CmdRead) |-> $stable(hostRdata))
	else begin
		failCount++;
		$error("hostRdata changed while hostAck was high");
	end

	// Load and read, fixed two-cycle latency
	fixedLatency: assert property (@(posedge clk) disable iff (!rstN)
		($rose(hostReq) && hostCmd != CmdRun) |-> !hostAck ##1 !hostAck ##1 hostAck)
	else begin
		failCount++;
		$error("load or read ack not two cycles after hostReq");
	end

	// Run ack needs eop in writeback first
	runDone: assert property (@(posedge clk) disable iff (!rstN)
		($rose(hostAck) && lastCmd == CmdRun) |-> eopDone)
	else begin
		failCount++;
		$error("run acknowledged before eop reached writeback");
	end

endmodule

bind pipelineCore pipelineCoreAssertions assertions_i (
	.clk       (clk),
	.rstN      (rstN),
	.hostReq   (hostReq),
	.hostCmd   (hostCmd),
	.hostAck   (hostAck),
	.hostRdata (hostRdata),
	.wbValid   (wbValid),
	.wbEop     (wbEop)
);

// File: pipelineCore.f
verilog/coreDefs.sv
verilog/hostPort.sv
verilog/fetchStage.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/pipelineCore.sv
bench/pipelineCore_assertions.sv
bench/pipelineCoreTb.sv

// File: verilog/coreDefs.sv
package coreDefs;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////
	localparam int DataWidth    = 32;
	localparam int RegAddrWidth = 5;

	typedef logic [DataWidth-1:0]    dataT;
	typedef logic [RegAddrWidth-1:0] regAddrT;

	// Opcode field, instr[31:26]
	localparam logic [5:0] OpRType = 6'd0;
	localparam logic [5:0] OpAddi  = 6'd8;
	localparam logic [5:0] OpAndi  = 6'd12;
	localparam logic [5:0] OpOri   = 6'd13;
	localparam logic [5:0] OpLui   = 6'd15;
	// End of program marker
	localparam logic [5:0] OpEop   = 6'd63;

	// Funct field of R-type, instr[5:0]
	localparam logic [5:0] FnSll = 6'd0;
	localparam logic [5:0] FnSrl = 6'd2;
	localparam logic [5:0] FnAdd = 6'd32;
	localparam logic [5:0] FnSub = 6'd34;
	localparam logic [5:0] FnAnd = 6'd36;
	localparam logic [5:0] FnOr  = 6'd37;
	localparam logic [5:0] FnXor = 6'd38;
	localparam logic [5:0] FnSlt = 6'd42;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSll, AluSrl
	} aluOpT;

	typedef enum logic [1:0] {CmdLoad, CmdRead, CmdRun} hostCmdT;

	// Shift amount forced into operand A for lui
	localparam int LuiShift = 16;

endpackage

// File: verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
	import coreDefs::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       ifValid,
	input  dataT       ifInstr,
	input  logic       wbRegWrite,
	input  regAddrT    wbDest,
	input  dataT       wbResult,
	input  regAddrT    hostRegAddr,
	output dataT       hostRegData,
	output logic       exValid,
	output aluOpT      exAluOp,
	output dataT       exOpA,
	output dataT       exOpB,
	output regAddrT    exRs,
	output regAddrT    exRt,
	output regAddrT    exDest,
	output logic       exRegWrite,
	output logic       exUseImm,
	output dataT       exImm,
	output logic [4:0] exShamt,
	output logic       exShiftImm,
	output logic       exLoadImm,
	output logic       exEop
);

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddrT    rs;
	regAddrT    rt;
	regAddrT    rd;
	aluOpT      aluOp;
	logic       regWrite;
	logic       useImm;
	logic       useRd;
	logic       shiftImm;
	logic       loadImm;
	logic       zeroExt;
	logic       isEop;
	dataT       imm;
	dataT       rdDataA;
	dataT       rdDataB;

	// Instruction fields
	assign opcode = ifInstr[31:26];
	assign rs     = ifInstr[25:21];
	assign rt     = ifInstr[20:16];
	assign rd     = ifInstr[15:11];
	assign funct  = ifInstr[5:0];

	registerFile regFile_i (
		.clk         (clk),
		.rstN        (rstN),
		.rdAddrA     (rs),
		.rdAddrB     (rt),
		.hostRegAddr (hostRegAddr),
		.weWrite     (wbRegWrite),
		.wrAddr      (wbDest),
		.wrData      (wbResult),
		.rdDataA     (rdDataA),
		.rdDataB     (rdDataB),
		.hostRegData (hostRegData)
	);

	////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////
	always_comb begin
		// Defaults give a no-op
		aluOp    = AluAdd;
		regWrite = 1'b0;
		useImm   = 1'b0;
		useRd    = 1'b0;
		shiftImm = 1'b0;
		loadImm  = 1'b0;
		zeroExt  = 1'b0;
		isEop    = 1'b0;
		case (opcode)
			OpRType: begin
				useRd    = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FnAdd: aluOp = AluAdd;
					FnSub: aluOp = AluSub;
					FnAnd: aluOp = AluAnd;
					FnOr:  aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnSlt: aluOp = AluSlt;
					// Shifts take shamt as operand A
					FnSll: begin
						aluOp    = AluSll;
						shiftImm = 1'b1;
					end
					FnSrl: begin
						aluOp    = AluSrl;
						shiftImm = 1'b1;
					end
					default: regWrite = 1'b0;
				endcase
			end
			OpAddi: begin
				regWrite = 1'b1;
				useImm   = 1'b1;
			end
			OpAndi: begin
				aluOp    = AluAnd;
				regWrite = 1'b1;
				useImm   = 1'b1;
				zeroExt  = 1'b1;
			end
			OpOri: begin
				aluOp    = AluOr;
				regWrite = 1'b1;
				useImm   = 1'b1;
				zeroExt  = 1'b1;
			end
			// imm << 16 through the shifter
			OpLui: begin
				aluOp    = AluSll;
				regWrite = 1'b1;
				useImm   = 1'b1;
				loadImm  = 1'b1;
			end
			OpEop: isEop = 1'b1;
			default: ;
		endcase
	end

	// Sign or zero extension of the 16-bit immediate
	assign imm = zeroExt ? {{(DataWidth-16){1'b0}}, ifInstr[15:0]}
		: {{(DataWidth-16){ifInstr[15]}}, ifInstr[15:0]};

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exValid    <= 1'b0;
			exRegWrite <= 1'b0;
			exEop      <= 1'b0;
		end else begin
			exValid    <= ifValid;
			exRegWrite <= ifValid && regWrite;
			exEop      <= ifValid && isEop;
		end
	end

	always_ff @(posedge clk) begin
		exAluOp    <= aluOp;
		exOpA      <= rdDataA;
		exOpB      <= rdDataB;
		exRs       <= rs;
		exRt       <= rt;
		exDest     <= useRd ? rd : rt;
		exUseImm   <= useImm;
		exImm      <= imm;
		exShamt    <= ifInstr[10:6];
		exShiftImm <= shiftImm;
		exLoadImm  <= loadImm;
	end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/1ps

module executeStage
	import coreDefs::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       exValid,
	input  aluOpT      exAluOp,
	input  dataT       exOpA,
	input  dataT       exOpB,
	input  regAddrT    exRs,
	input  regAddrT    exRt,
	input  regAddrT    exDest,
	input  logic       exRegWrite,
	input  logic       exUseImm,
	input  dataT       exImm,
	input  logic [4:0] exShamt,
	input  logic       exShiftImm,
	input  logic       exLoadImm,
	input  logic       exEop,
	output logic       wbValid,
	output regAddrT    wbDest,
	output logic       wbRegWrite,
	output dataT       wbResult,
	output logic       wbEop,
	output logic       wbDoneEop
);

	dataT fwdA;
	dataT fwdB;
	dataT srcA;
	dataT srcB;
	dataT aluResult;

	////////////////////////////////////////////////////////////
	// Forwarding from EX/WB
	////////////////////////////////////////////////////////////
	// Older results already sit in the register file
	assign fwdA = (wbRegWrite && wbDest == exRs && exRs != '0) ? wbResult : exOpA;
	assign fwdB = (wbRegWrite && wbDest == exRt && exRt != '0) ? wbResult : exOpB;

	// Operand A: register, shamt, or 16 for lui
	always_comb begin
		if (exLoadImm) begin
			srcA = dataT'(LuiShift);
		end else if (exShiftImm) begin
			srcA = dataT'(exShamt);
		end else begin
			srcA = fwdA;
		end
	end

	// Operand B: register or extended immediate
	assign srcB = exUseImm ? exImm : fwdB;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (exAluOp)
			AluAdd:  aluResult = srcA + srcB;
			AluSub:  aluResult = srcA - srcB;
			AluAnd:  aluResult = srcA & srcB;
			AluOr:   aluResult = srcA | srcB;
			AluXor:  aluResult = srcA ^ srcB;
			// Signed compare
			AluSlt:  aluResult = dataT'($signed(srcA) < $signed(srcB));
			// Value in B, amount in A
			AluSll:  aluResult = srcB << srcA[4:0];
			AluSrl:  aluResult = srcB >> srcA[4:0];
			default: aluResult = '0;
		endcase
	end

	// EX/WB register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid    <= 1'b0;
			wbRegWrite <= 1'b0;
			wbEop      <= 1'b0;
		end else begin
			wbValid    <= exValid;
			wbRegWrite <= exValid && exRegWrite;
			wbEop      <= exValid && exEop;
		end
	end

	always_ff @(posedge clk) begin
		wbDest   <= exDest;
		wbResult <= aluResult;
	end

	// Run complete, eop reached writeback
	assign wbDoneEop = wbValid && wbEop;

endmodule

// File: verilog/fetchStage.sv
`timescale 1ns/1ps

module fetchStage
	import coreDefs::*;
#(
	parameter int ImemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     runStart,
	input  logic                     imemWe,
	input  logic [ImemAddrWidth-1:0] imemAddr,
	input  dataT                     imemWdata,
	output logic                     ifValid,
	output dataT                     ifInstr
);

	localparam int ImemDepth = 2 ** ImemAddrWidth;

	dataT                     imem [ImemDepth];
	logic [ImemAddrWidth-1:0] pc;
	logic                     running;
	logic                     eopSeen;

	// Eop sitting in IF/ID stops issue at this edge
	assign eopSeen = ifValid && (ifInstr[31:26] == OpEop);

	////////////////////////////////////////////////////////////
	// Program counter and run flag
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc      <= '0;
			running <= 1'b0;
			ifValid <= 1'b0;
		end else begin
			ifValid <= running && !eopSeen;
			if (runStart) begin
				pc      <= '0;
				running <= 1'b1;
			end else if (running) begin
				if (eopSeen) begin
					running <= 1'b0;
				end else begin
					pc <= pc + 1'b1;
				end
			end
		end
	end

	// Synchronous memory, read port feeds IF/ID directly
	always_ff @(posedge clk) begin
		// Host loads only while the core is idle
		if (imemWe && !running) begin
			imem[imemAddr] <= imemWdata;
		end
		ifInstr <= imem[pc];
	end

endmodule

// File: verilog/hostPort.sv
`timescale 1ns/1ps

module hostPort
	import coreDefs::*;
#(
	parameter int ImemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     hostReq,
	input  hostCmdT                  hostCmd,
	input  logic [ImemAddrWidth-1:0] hostAddr,
	input  dataT                     hostWdata,
	input  logic                     wbDoneEop,
	input  dataT                     hostRegData,
	output logic                     hostAck,
	output dataT                     hostRdata,
	output logic                     imemWe,
	output logic [ImemAddrWidth-1:0] imemAddr,
	output dataT                     imemWdata,
	output logic                     runStart,
	output regAddrT                  hostRegAddr
);

	typedef enum logic [1:0] {StIdle, StBusy, StAck} stateT;

	stateT   state;
	hostCmdT cmdQ;

	// Latched address doubles as register index for reads
	assign hostRegAddr = regAddrT'(imemAddr);

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state    <= StIdle;
			cmdQ     <= CmdLoad;
			hostAck  <= 1'b0;
			runStart <= 1'b0;
			imemWe   <= 1'b0;
		end else begin
			// Single-cycle strobes
			runStart <= 1'b0;
			imemWe   <= 1'b0;
			case (state)
				StIdle: begin
					if (hostReq) begin
						cmdQ     <= hostCmd;
						state    <= StBusy;
						imemWe   <= (hostCmd == CmdLoad);
						runStart <= (hostCmd == CmdRun);
					end
				end
				StBusy: begin
					// Load and read finish here, run waits for eop in WB
					if (cmdQ != CmdRun || wbDoneEop) begin
						state   <= StAck;
						hostAck <= 1'b1;
					end
				end
				StAck: begin
					// Hold ack until host lets go of req
					if (!hostReq) begin
						state   <= StIdle;
						hostAck <= 1'b0;
					end
				end
				default: state <= StIdle;
			endcase
		end
	end

	// Request fields and read data
	always_ff @(posedge clk) begin
		if (state == StIdle && hostReq) begin
			imemAddr  <= hostAddr;
			imemWdata <= hostWdata;
		end
		// Register value settles during the busy cycle
		if (state == StBusy && cmdQ == CmdRead) begin
			hostRdata <= hostRegData;
		end
	end

endmodule

// File: verilog/pipelineCore.sv
`timescale 1ns/1ps

module pipelineCore
	import coreDefs::*;
#(
	parameter int ImemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     hostReq,
	input  hostCmdT                  hostCmd,
	input  logic [ImemAddrWidth-1:0] hostAddr,
	input  dataT                     hostWdata,
	output logic                     hostAck,
	output dataT                     hostRdata
);

	// Host to fetch and register file
	logic                     imemWe;
	logic [ImemAddrWidth-1:0] imemAddr;
	dataT                     imemWdata;
	logic                     runStart;
	regAddrT                  hostRegAddr;
	dataT                     hostRegData;

	// IF/ID
	logic ifValid;
	dataT ifInstr;

	// ID/EX
	logic       exValid;
	aluOpT      exAluOp;
	dataT       exOpA;
	dataT       exOpB;
	regAddrT    exRs;
	regAddrT    exRt;
	regAddrT    exDest;
	logic       exRegWrite;
	logic       exUseImm;
	dataT       exImm;
	logic [4:0] exShamt;
	logic       exShiftImm;
	logic       exLoadImm;
	logic       exEop;

	// EX/WB
	logic    wbValid;
	regAddrT wbDest;
	logic    wbRegWrite;
	dataT    wbResult;
	logic    wbEop;
	logic    wbDoneEop;

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////
	hostPort #(
		.ImemAddrWidth (ImemAddrWidth)
	) hostPort_i (
		.clk         (clk),
		.rstN        (rstN),
		.hostReq     (hostReq),
		.hostCmd     (hostCmd),
		.hostAddr    (hostAddr),
		.hostWdata   (hostWdata),
		.wbDoneEop   (wbDoneEop),
		.hostRegData (hostRegData),
		.hostAck     (hostAck),
		.hostRdata   (hostRdata),
		.imemWe      (imemWe),
		.imemAddr    (imemAddr),
		.imemWdata   (imemWdata),
		.runStart    (runStart),
		.hostRegAddr (hostRegAddr)
	);

	////////////////////////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////////////////////////
	fetchStage #(
		.ImemAddrWidth (ImemAddrWidth)
	) fetchStage_i (
		.clk       (clk),
		.rstN      (rstN),
		.runStart  (runStart),
		.imemWe    (imemWe),
		.imemAddr  (imemAddr),
		.imemWdata (imemWdata),
		.ifValid   (ifValid),
		.ifInstr   (ifInstr)
	);

	// Register file lives here, written back from execute
	decodeStage decodeStage_i (
		.clk         (clk),
		.rstN        (rstN),
		.ifValid     (ifValid),
		.ifInstr     (ifInstr),
		.wbRegWrite  (wbRegWrite),
		.wbDest      (wbDest),
		.wbResult    (wbResult),
		.hostRegAddr (hostRegAddr),
		.hostRegData (hostRegData),
		.exValid     (exValid),
		.exAluOp     (exAluOp),
		.exOpA       (exOpA),
		.exOpB       (exOpB),
		.exRs        (exRs),
		.exRt        (exRt),
		.exDest      (exDest),
		.exRegWrite  (exRegWrite),
		.exUseImm    (exUseImm),
		.exImm       (exImm),
		.exShamt     (exShamt),
		.exShiftImm  (exShiftImm),
		.exLoadImm   (exLoadImm),
		.exEop       (exEop)
	);

	executeStage executeStage_i (
		.clk        (clk),
		.rstN       (rstN),
		.exValid    (exValid),
		.exAluOp    (exAluOp),
		.exOpA      (exOpA),
		.exOpB      (exOpB),
		.exRs       (exRs),
		.exRt       (exRt),
		.exDest     (exDest),
		.exRegWrite (exRegWrite),
		.exUseImm   (exUseImm),
		.exImm      (exImm),
		.exShamt    (exShamt),
		.exShiftImm (exShiftImm),
		.exLoadImm  (exLoadImm),
		.exEop      (exEop),
		.wbValid    (wbValid),
		.wbDest     (wbDest),
		.wbRegWrite (wbRegWrite),
		.wbResult   (wbResult),
		.wbEop      (wbEop),
		.wbDoneEop  (wbDoneEop)
	);

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile
	import coreDefs::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  regAddrT rdAddrA,
	input  regAddrT rdAddrB,
	input  regAddrT hostRegAddr,
	input  logic    weWrite,
	input  regAddrT wrAddr,
	input  dataT    wrData,
	output dataT    rdDataA,
	output dataT    rdDataB,
	output dataT    hostRegData
);

	dataT regs [2 ** RegAddrWidth];

	// R0 hardwired, same-cycle write passes through
	function automatic dataT readReg(regAddrT addr);
		if (addr == '0) begin
			return '0;
		end
		if (weWrite && addr == wrAddr) begin
			return wrData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdDataA     = readReg(rdAddrA);
		rdDataB     = readReg(rdAddrB);
		hostRegData = readReg(hostRegAddr);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2 ** RegAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (weWrite && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule
